/* design/bg_fetcher.sv */
`timescale 1ns/1ns

module bg_fetcher
(
    input  logic                clk,
    input  logic                rst,

    input  ppu_pkg::ppu_cfg_t   cfg,
    input  ppu_pkg::ppu_mode_t  mode,
    input  ppu_pkg::ly_t        ly,

    input  ppu_pkg::byte_t      ppu_data,
    input  logic                buf_free,
    output logic                ppu_rd,
    output ppu_pkg::vaddr_t     ppu_addr,

    output ppu_pkg::tile_row_t  row,
    output logic                row_load
);

    logic [4:0]      col;           // Tile column, wraps across the map
    logic [1:0]      step;          // Map byte, low plane, high plane
    ppu_pkg::byte_t  by;            // Background row in map space
    ppu_pkg::byte_t  tile_idx;
    ppu_pkg::byte_t  plane_lo_q;

    ppu_pkg::vaddr_t map_base;
    ppu_pkg::vaddr_t map_addr;
    ppu_pkg::vaddr_t tile_base;
    ppu_pkg::vaddr_t tile_offs;
    ppu_pkg::vaddr_t row_addr;

    assign by = ly + cfg.scy;

    // Tile map byte
    assign map_base = cfg.bg_map_sel ? ppu_pkg::MAP_BASE_HI : ppu_pkg::MAP_BASE_LO;
    assign map_addr = map_base
                    + ppu_pkg::vaddr_t'(by[7:3]) * ppu_pkg::MAP_TILES_PER_ROW
                    + ppu_pkg::vaddr_t'(col);

    // Tile data row, signed index in the 9000 region
    assign tile_base = cfg.tile_data_sel ? ppu_pkg::TILE_BASE_UNSIGNED
                                         : ppu_pkg::TILE_BASE_SIGNED;
    assign tile_offs = cfg.tile_data_sel ? {8'd0, tile_idx}
                                         : {{8{tile_idx[7]}}, tile_idx};
    assign row_addr  = tile_base
                     + tile_offs * ppu_pkg::BYTES_PER_TILE
                     + ppu_pkg::vaddr_t'({by[2:0], 1'b0});

    assign ppu_rd   = (mode == ppu_pkg::RENDER) && buf_free;
    assign row_load = ppu_rd && (step == 2'd2);

    // High plane goes straight through on the load cycle
    assign row.plane_lo = plane_lo_q;
    assign row.plane_hi = ppu_data;

    always_comb
    begin
        ppu_addr = '0;
        if (ppu_rd)
        begin
            case (step)
                2'd0:    ppu_addr = map_addr;
                2'd1:    ppu_addr = row_addr;
                default: ppu_addr = row_addr + 16'd1;
            endcase
        end
    end

    // Fetch sequencing
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            step <= '0;
            col  <= '0;
        end
        else if (mode != ppu_pkg::RENDER)
        begin
            step <= '0;
            col  <= cfg.scx[7:3];   // Coarse scroll for the next line
        end
        else if (ppu_rd)
        begin
            if (step == 2'd2)
            begin
                step <= '0;
                col  <= col + 5'd1;
            end
            else
            begin
                step <= step + 2'd1;
            end
        end
    end

    // Captured bytes
    always_ff @(posedge clk)
    begin
        if (ppu_rd && step == 2'd0)
            tile_idx <= ppu_data;
        if (ppu_rd && step == 2'd1)
            plane_lo_q <= ppu_data;
    end

endmodule

/* design/bg_pixel_pipe.sv */
`timescale 1ns/1ns

module bg_pixel_pipe
(
    input  logic                clk,
    input  logic                rst,

    input  ppu_pkg::ppu_cfg_t   cfg,
    input  ppu_pkg::ppu_mode_t  mode,

    input  ppu_pkg::tile_row_t  row,
    input  logic                row_load,
    output logic                buf_free,

    output ppu_pkg::shade_t     px_out,
    output logic                px_valid,
    output logic                line_done
);

    ppu_pkg::tile_row_t [1:0] rows;
    logic [1:0]         row_valid;
    logic               sel;            // Buffer shifting out
    logic [2:0]         bit_cnt;        // Pixels taken from the current row
    logic [2:0]         discard;        // Fine scroll pixels dropped
    ppu_pkg::byte_t     px_cnt;

    logic               run;
    logic               shift;
    logic               load_sel;
    ppu_pkg::tile_row_t cur;
    ppu_pkg::shade_t    color;

    assign run      = (mode == ppu_pkg::RENDER);
    assign cur      = rows[sel];
    assign shift    = run && row_valid[sel];
    assign buf_free = !(row_valid[0] && row_valid[1]);

    // Fill the idle buffer, or the current one when both are empty
    assign load_sel = row_valid[sel] ? !sel : sel;

    assign color     = {cur.plane_hi[7], cur.plane_lo[7]};
    assign px_valid  = shift && (discard == cfg.scx[2:0]);
    assign px_out    = cfg.bg_en ? cfg.bgp[{color, 1'b0} +: 2] : 2'b00;
    assign line_done = px_valid && (px_cnt == ppu_pkg::SCREEN_WIDTH - 8'd1);

    always_ff @(posedge clk)
    begin
        if (rst || !run)
        begin
            row_valid <= '0;
            sel       <= 1'b0;
            bit_cnt   <= '0;
            discard   <= '0;
            px_cnt    <= '0;
        end
        else
        begin
            if (row_load)
                row_valid[load_sel] <= 1'b1;
            if (shift)
            begin
                bit_cnt <= bit_cnt + 3'd1;
                if (discard != cfg.scx[2:0])
                    discard <= discard + 3'd1;
                else
                    px_cnt <= px_cnt + 8'd1;
                if (bit_cnt == 3'd7)
                begin
                    row_valid[sel] <= 1'b0;     // Row used up, swap
                    sel            <= !sel;
                end
            end
        end
    end

    // Row data, shifted toward bit 7
    always_ff @(posedge clk)
    begin
        if (row_load)
            rows[load_sel] <= row;
        if (shift)
        begin
            rows[sel].plane_lo <= {rows[sel].plane_lo[6:0], 1'b0};
            rows[sel].plane_hi <= {rows[sel].plane_hi[6:0], 1'b0};
        end
    end

endmodule

/* design/ppu_pkg.sv */
package ppu_pkg;

    // Widths that carry a meaning
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] vaddr_t;
    typedef logic [7:0]  ly_t;
    typedef logic [8:0]  dot_t;
    typedef logic [1:0]  shade_t;

    // Encoding matches the STAT mode field
    typedef enum logic [1:0] {
        HBLANK   = 2'd0,
        VBLANK   = 2'd1,
        OAM_SCAN = 2'd2,
        RENDER   = 2'd3
    } ppu_mode_t;

    // Decoded configuration seen by the rendering blocks
    typedef struct packed {
        logic  lcd_en;        // LCDC bit 7
        logic  bg_map_sel;    // LCDC bit 3
        logic  tile_data_sel; // LCDC bit 4
        logic  bg_en;         // LCDC bit 0
        byte_t scx;
        byte_t scy;
        byte_t bgp;
    } ppu_cfg_t;

    // One fetched tile row, leftmost pixel in bit 7
    typedef struct packed {
        byte_t plane_lo;
        byte_t plane_hi;
    } tile_row_t;

    // Register map
    localparam vaddr_t ADDR_LCDC = 16'hFF40;
    localparam vaddr_t ADDR_STAT = 16'hFF41;
    localparam vaddr_t ADDR_SCY  = 16'hFF42;
    localparam vaddr_t ADDR_SCX  = 16'hFF43;
    localparam vaddr_t ADDR_LY   = 16'hFF44;
    localparam vaddr_t ADDR_LYC  = 16'hFF45;
    localparam vaddr_t ADDR_BGP  = 16'hFF47;

    // Video memory layout
    localparam vaddr_t MAP_BASE_LO        = 16'h9800;
    localparam vaddr_t MAP_BASE_HI        = 16'h9C00;
    localparam vaddr_t TILE_BASE_UNSIGNED = 16'h8000;
    localparam vaddr_t TILE_BASE_SIGNED   = 16'h9000;
    localparam vaddr_t MAP_TILES_PER_ROW  = 16'd32;
    localparam vaddr_t BYTES_PER_TILE     = 16'd16;

    // Line and frame timing
    localparam dot_t  DOTS_PER_LINE = 9'd456;
    localparam dot_t  OAM_SCAN_DOTS = 9'd80;
    localparam ly_t   VISIBLE_LINES = 8'd144;
    localparam ly_t   TOTAL_LINES   = 8'd154;
    localparam byte_t SCREEN_WIDTH  = 8'd160;

endpackage

/* design/ppu_regs.sv */
`timescale 1ns/1ns

module ppu_regs
(
    input  logic                clk,
    input  logic                rst,

    input  ppu_pkg::vaddr_t     addr,
    input  logic                wr,
    input  ppu_pkg::byte_t      mmio_wdata,
    output ppu_pkg::byte_t      mmio_rdata,

    input  ppu_pkg::ppu_mode_t  mode,
    input  ppu_pkg::ly_t        ly,

    output ppu_pkg::ppu_cfg_t   cfg,
    output logic                irq_stat
);

    ppu_pkg::byte_t lcdc;
    ppu_pkg::byte_t scy;
    ppu_pkg::byte_t scx;
    ppu_pkg::byte_t lyc;
    ppu_pkg::byte_t bgp;
    logic [3:0]     stat_en;        // STAT bits 6:3

    logic           coincidence;
    logic           stat_level;
    logic           stat_level_q;

    // Register writes
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            lcdc    <= '0;
            scy     <= '0;
            scx     <= '0;
            lyc     <= '0;
            bgp     <= '0;
            stat_en <= '0;
        end
        else if (wr)
        begin
            case (addr)
                ppu_pkg::ADDR_LCDC: lcdc    <= mmio_wdata;
                ppu_pkg::ADDR_STAT: stat_en <= mmio_wdata[6:3]; // Low bits are status
                ppu_pkg::ADDR_SCY:  scy     <= mmio_wdata;
                ppu_pkg::ADDR_SCX:  scx     <= mmio_wdata;
                ppu_pkg::ADDR_LYC:  lyc     <= mmio_wdata;
                ppu_pkg::ADDR_BGP:  bgp     <= mmio_wdata;
                default: ;                                      // LY is read only
            endcase
        end
    end

    // LCDC decode
    assign cfg.lcd_en        = lcdc[7];
    assign cfg.tile_data_sel = lcdc[4];
    assign cfg.bg_map_sel    = lcdc[3];
    assign cfg.bg_en         = lcdc[0];
    assign cfg.scx           = scx;
    assign cfg.scy           = scy;
    assign cfg.bgp           = bgp;

    assign coincidence = (ly == lyc);

    // Read path
    always_comb
    begin
        case (addr)
            ppu_pkg::ADDR_LCDC: mmio_rdata = lcdc;
            ppu_pkg::ADDR_STAT: mmio_rdata = {1'b1, stat_en, coincidence, mode};
            ppu_pkg::ADDR_SCY:  mmio_rdata = scy;
            ppu_pkg::ADDR_SCX:  mmio_rdata = scx;
            ppu_pkg::ADDR_LY:   mmio_rdata = ly;
            ppu_pkg::ADDR_LYC:  mmio_rdata = lyc;
            ppu_pkg::ADDR_BGP:  mmio_rdata = bgp;
            default:            mmio_rdata = 8'hFF;
        endcase
    end

    // Combined STAT source level, only while the LCD runs
    always_comb
    begin
        stat_level = (stat_en[3] && coincidence) ||
                     (stat_en[0] && mode == ppu_pkg::HBLANK) ||
                     (stat_en[1] && mode == ppu_pkg::VBLANK) ||
                     (stat_en[2] && mode == ppu_pkg::OAM_SCAN);
        stat_level = stat_level && cfg.lcd_en;
    end

    // Rising edge of the level gives a single pulse
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            stat_level_q <= 1'b0;
            irq_stat     <= 1'b0;
        end
        else
        begin
            stat_level_q <= stat_level;
            irq_stat     <= stat_level && !stat_level_q;
        end
    end

endmodule

/* design/ppu_timing.sv */
`timescale 1ns/1ns

module ppu_timing
(
    input  logic                clk,
    input  logic                rst,

    input  ppu_pkg::ppu_cfg_t   cfg,
    input  logic                line_done,

    output ppu_pkg::ppu_mode_t  mode,
    output ppu_pkg::ly_t        ly,
    output logic                irq_vblank
);

    ppu_pkg::dot_t dot;         // Cycle within the current line
    logic          running;     // First line has been started
    logic          line_end;

    assign line_end = (dot == ppu_pkg::DOTS_PER_LINE - 9'd1);

    always_ff @(posedge clk)
    begin
        if (rst || !cfg.lcd_en)
        begin
            // LCD off holds everything at line 0
            mode       <= ppu_pkg::HBLANK;
            ly         <= '0;
            dot        <= '0;
            running    <= 1'b0;
            irq_vblank <= 1'b0;
        end
        else if (!running)
        begin
            running <= 1'b1;
            mode    <= ppu_pkg::OAM_SCAN;   // Dot 0 of line 0 follows
        end
        else
        begin
            irq_vblank <= 1'b0;
            dot        <= line_end ? '0 : dot + 9'd1;

            case (mode)
                ppu_pkg::OAM_SCAN:
                begin
                    // No reads here, timing only
                    if (dot == ppu_pkg::OAM_SCAN_DOTS - 9'd1)
                        mode <= ppu_pkg::RENDER;
                end

                ppu_pkg::RENDER:
                begin
                    if (line_done)
                        mode <= ppu_pkg::HBLANK;    // Length depends on fine scroll
                end

                ppu_pkg::HBLANK:
                begin
                    if (line_end)
                    begin
                        ly <= ly + 8'd1;
                        if (ly == ppu_pkg::VISIBLE_LINES - 8'd1)
                        begin
                            mode       <= ppu_pkg::VBLANK;
                            irq_vblank <= 1'b1;     // First cycle of line 144
                        end
                        else
                        begin
                            mode <= ppu_pkg::OAM_SCAN;
                        end
                    end
                end

                ppu_pkg::VBLANK:
                begin
                    if (line_end)
                    begin
                        if (ly == ppu_pkg::TOTAL_LINES - 8'd1)
                        begin
                            ly   <= '0;
                            mode <= ppu_pkg::OAM_SCAN;  // New frame
                        end
                        else
                        begin
                            ly <= ly + 8'd1;
                        end
                    end
                end

                default: mode <= ppu_pkg::HBLANK;
            endcase
        end
    end

endmodule

/* design/ppu_top.sv */
`timescale 1ns/1ns

module ppu_top
(
    input  logic                clk,
    input  logic                rst,

    // Register bus
    input  ppu_pkg::vaddr_t     addr,
    input  logic                wr,
    input  ppu_pkg::byte_t      mmio_wdata,
    output ppu_pkg::byte_t      mmio_rdata,

    output logic                irq_vblank,
    output logic                irq_stat,
    output ppu_pkg::ppu_mode_t  mode,

    // Video memory
    output logic                ppu_rd,
    output ppu_pkg::vaddr_t     ppu_addr,
    input  ppu_pkg::byte_t      ppu_data,

    // Pixels
    output ppu_pkg::shade_t     px_out,
    output logic                px_valid
);

    ppu_pkg::ppu_cfg_t  cfg;
    ppu_pkg::ly_t       ly;
    ppu_pkg::tile_row_t row;
    logic               row_load;
    logic               buf_free;
    logic               line_done;

    ppu_regs i_ppu_regs (
        .clk        (clk),
        .rst        (rst),
        .addr       (addr),
        .wr         (wr),
        .mmio_wdata (mmio_wdata),
        .mmio_rdata (mmio_rdata),
        .mode       (mode),
        .ly         (ly),
        .cfg        (cfg),
        .irq_stat   (irq_stat)
    );

    ppu_timing i_ppu_timing (
        .clk        (clk),
        .rst        (rst),
        .cfg        (cfg),
        .line_done  (line_done),
        .mode       (mode),
        .ly         (ly),
        .irq_vblank (irq_vblank)
    );

    bg_fetcher i_bg_fetcher (
        .clk        (clk),
        .rst        (rst),
        .cfg        (cfg),
        .mode       (mode),
        .ly         (ly),
        .ppu_data   (ppu_data),
        .buf_free   (buf_free),
        .ppu_rd     (ppu_rd),
        .ppu_addr   (ppu_addr),
        .row        (row),
        .row_load   (row_load)
    );

    bg_pixel_pipe i_bg_pixel_pipe (
        .clk        (clk),
        .rst        (rst),
        .cfg        (cfg),
        .mode       (mode),
        .row        (row),
        .row_load   (row_load),
        .buf_free   (buf_free),
        .px_out     (px_out),
        .px_valid   (px_valid),
        .line_done  (line_done)
    );

endmodule

/* ppu_top.f */
design/ppu_pkg.sv
design/ppu_regs.sv
design/ppu_timing.sv
design/bg_fetcher.sv
design/bg_pixel_pipe.sv
design/ppu_top.sv
tb/vram_model.sv
tb/ppu_tb.sv

/* tb/ppu_tb.sv */
`timescale 1ns/1ns

module ppu_tb;

    localparam int LINE_CYCLES    = 456;
    localparam int FRAME_CYCLES   = 70224;
    localparam int VISIBLE_LINES  = 144;
    localparam int TOTAL_LINES    = 154;
    localparam int VRAM_BASE      = 'h8000;
    localparam int HBLANK_LINES   = 32;
    localparam int HBLANK_START   = 80 + 3 + 160;   // Three fetch cycles, then 160 pixels at scx 0
    localparam int TIMEOUT_CYCLES = 400000;    // Tests take about 330000 cycles

    logic               clk;
    logic               rst;
    ppu_pkg::vaddr_t    addr;
    logic               wr;
    ppu_pkg::byte_t     mmio_wdata;
    ppu_pkg::byte_t     mmio_rdata;
    logic               irq_vblank;
    logic               irq_stat;
    ppu_pkg::ppu_mode_t mode;
    logic               ppu_rd;
    ppu_pkg::vaddr_t    ppu_addr;
    ppu_pkg::byte_t     ppu_data;
    ppu_pkg::shade_t    px_out;
    logic               px_valid;

    ppu_pkg::byte_t     vram_copy [0:8191];  // Reference copy of video memory
    logic [15:0]        lfsr;
    int                 error_count = 0;
    int                 tests_run = 0;
    int                 cycle_count = 0;

    ppu_top i_ppu_top (
        .clk        (clk),
        .rst        (rst),
        .addr       (addr),
        .wr         (wr),
        .mmio_wdata (mmio_wdata),
        .mmio_rdata (mmio_rdata),
        .irq_vblank (irq_vblank),
        .irq_stat   (irq_stat),
        .mode       (mode),
        .ppu_rd     (ppu_rd),
        .ppu_addr   (ppu_addr),
        .ppu_data   (ppu_data),
        .px_out     (px_out),
        .px_valid   (px_valid)
    );

    vram_model i_vram_model (
        .addr (ppu_addr),
        .rd   (ppu_rd),
        .data (ppu_data)
    );

    always #4 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("Run stopped, no result after %0d cycles", cycle_count);
            $display("TEST FAIL");
            $finish;
        end
    end

    task automatic report_error(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        error_count++;
        $display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
    endtask

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] next_lfsr(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    task automatic random_byte(output ppu_pkg::byte_t value);
        int i;
        value = '0;
        for (i = 0; i < 8; i++)
        begin
            lfsr  = next_lfsr(lfsr);     // One step per bit
            value = {value[6:0], lfsr[0]};
        end
    endtask

    task automatic load_vram();
        int i;
        ppu_pkg::byte_t value;
        for (i = 0; i < 8192; i++)
        begin
            random_byte(value);
            vram_copy[i] = value;
            i_vram_model.mem[i] = value;
        end
    endtask

    task automatic write_reg(input ppu_pkg::vaddr_t a, input ppu_pkg::byte_t d);
        @(negedge clk);
        addr       = a;
        wr         = 1'b1;
        mmio_wdata = d;
        @(negedge clk);
        wr = 1'b0;
    endtask

    task automatic read_reg(input ppu_pkg::vaddr_t a, output ppu_pkg::byte_t value);
        @(negedge clk);
        addr = a;
        wr   = 1'b0;
        @(negedge clk);
        value = mmio_rdata;
    endtask

    // Background shade of screen pixel (x, line) from the reference memory
    function automatic ppu_pkg::shade_t expected_shade(input int line, input int x,
                                                       input ppu_pkg::byte_t lcdc,
                                                       input ppu_pkg::byte_t scx,
                                                       input ppu_pkg::byte_t scy,
                                                       input ppu_pkg::byte_t bgp);
        int by;
        int bx;
        int map_addr;
        int tile;
        int row_addr;
        int bit_pos;
        int color;
        by       = (line + scy) % 256;
        bx       = (x + scx) % 256;
        map_addr = (lcdc[3] ? 'h9C00 : 'h9800) + (by / 8) * 32 + bx / 8;
        tile     = vram_copy[map_addr - VRAM_BASE];
        if (lcdc[4])
            row_addr = 'h8000 + tile * 16 + (by % 8) * 2;
        else
            row_addr = 'h9000 + (tile < 128 ? tile : tile - 256) * 16 + (by % 8) * 2;
        bit_pos = 7 - bx % 8;
        color   = 2 * vram_copy[row_addr + 1 - VRAM_BASE][bit_pos]
                + vram_copy[row_addr - VRAM_BASE][bit_pos];
        return lcdc[0] ? bgp[2 * color +: 2] : 2'b00;
    endfunction

    task automatic register_access();
        ppu_pkg::byte_t value;
        tests_run++;
        write_reg(ppu_pkg::ADDR_LCDC, 8'h5A);           // LCD stays off
        read_reg(ppu_pkg::ADDR_LCDC, value);
        if (value !== 8'h5A)
            report_error("register_access LCDC", 8'h5A, value);
        write_reg(ppu_pkg::ADDR_SCY, 8'hA5);
        read_reg(ppu_pkg::ADDR_SCY, value);
        if (value !== 8'hA5)
            report_error("register_access SCY", 8'hA5, value);
        write_reg(ppu_pkg::ADDR_SCX, 8'h3C);
        read_reg(ppu_pkg::ADDR_SCX, value);
        if (value !== 8'h3C)
            report_error("register_access SCX", 8'h3C, value);
        write_reg(ppu_pkg::ADDR_LYC, 8'h99);
        read_reg(ppu_pkg::ADDR_LYC, value);
        if (value !== 8'h99)
            report_error("register_access LYC", 8'h99, value);
        write_reg(ppu_pkg::ADDR_BGP, 8'hE4);
        read_reg(ppu_pkg::ADDR_BGP, value);
        if (value !== 8'hE4)
            report_error("register_access BGP", 8'hE4, value);
        // LY 0 against LYC 99, mode HBLANK
        write_reg(ppu_pkg::ADDR_STAT, 8'hFF);
        read_reg(ppu_pkg::ADDR_STAT, value);
        if (value !== 8'hF8)
            report_error("register_access STAT all ones", 8'hF8, value);
        write_reg(ppu_pkg::ADDR_STAT, 8'h07);
        read_reg(ppu_pkg::ADDR_STAT, value);
        if (value !== 8'h80)
            report_error("register_access STAT low bits", 8'h80, value);
        write_reg(ppu_pkg::ADDR_LYC, 8'h00);
        read_reg(ppu_pkg::ADDR_STAT, value);
        if (value !== 8'h84)
            report_error("register_access STAT coincidence", 8'h84, value);
        write_reg(ppu_pkg::ADDR_LY, 8'h55);
        read_reg(ppu_pkg::ADDR_LY, value);
        if (value !== 8'h00)
            report_error("register_access LY write", 8'h00, value);
        read_reg(16'hFF46, value);
        if (value !== 8'hFF)
            report_error("register_access FF46", 8'hFF, value);
        read_reg(16'hFF4A, value);
        if (value !== 8'hFF)
            report_error("register_access FF4A", 8'hFF, value);
        write_reg(ppu_pkg::ADDR_LCDC, 8'h00);
        write_reg(ppu_pkg::ADDR_STAT, 8'h00);
        write_reg(ppu_pkg::ADDR_SCY, 8'h00);
        write_reg(ppu_pkg::ADDR_SCX, 8'h00);
        write_reg(ppu_pkg::ADDR_BGP, 8'h00);
    endtask

    task automatic frame_timing();
        int k;
        int line;
        int dot;
        int pulses;
        logic want_irq;
        ppu_pkg::ppu_mode_t want_mode;
        tests_run++;
        write_reg(ppu_pkg::ADDR_LCDC, 8'h00);
        write_reg(ppu_pkg::ADDR_LCDC, 8'h91);
        addr   = ppu_pkg::ADDR_LY;
        pulses = 0;
        for (k = 1; k <= 2 * FRAME_CYCLES; k++)
        begin
            @(negedge clk);
            line = ((k - 1) / LINE_CYCLES) % TOTAL_LINES;   // Line 0 starts at k = 1
            dot  = (k - 1) % LINE_CYCLES;
            if (mmio_rdata !== 8'(line))
                report_error("frame_timing LY", line, mmio_rdata);
            if (line >= VISIBLE_LINES)
                want_mode = ppu_pkg::VBLANK;
            else if (dot < 80)
                want_mode = ppu_pkg::OAM_SCAN;
            else if (dot < HBLANK_START)
                want_mode = ppu_pkg::RENDER;
            else
                want_mode = ppu_pkg::HBLANK;
            if (mode !== want_mode)
                report_error("frame_timing mode", want_mode, mode);
            want_irq = (line == VISIBLE_LINES) && (dot == 0);
            if (irq_vblank !== want_irq)
                report_error("frame_timing irq_vblank", want_irq, irq_vblank);
            if (irq_vblank)
                pulses++;
        end
        if (pulses !== 2)
            report_error("frame_timing vblank pulses", 2, pulses);
    endtask

    task automatic background_pixels(input string name, input ppu_pkg::byte_t lcdc,
                                     input ppu_pkg::byte_t scx, input ppu_pkg::byte_t scy,
                                     input int lines);
        int k;
        int line;
        int dot;
        int px_count;
        ppu_pkg::byte_t bgp;
        ppu_pkg::shade_t want;
        tests_run++;
        random_byte(bgp);
        write_reg(ppu_pkg::ADDR_LCDC, 8'h00);
        write_reg(ppu_pkg::ADDR_SCX, scx);
        write_reg(ppu_pkg::ADDR_SCY, scy);
        write_reg(ppu_pkg::ADDR_BGP, bgp);
        write_reg(ppu_pkg::ADDR_LCDC, lcdc);
        px_count = 0;
        for (k = 1; k <= lines * LINE_CYCLES; k++)
        begin
            @(negedge clk);
            line = (k - 1) / LINE_CYCLES;
            dot  = (k - 1) % LINE_CYCLES;
            if (px_valid)
            begin
                want = expected_shade(line, px_count, lcdc, scx, scy, bgp);
                if (px_out !== want)
                    report_error($sformatf("%s line %0d x %0d", name, line, px_count),
                                 want, px_out);
                px_count++;
            end
            if (dot == LINE_CYCLES - 1)
            begin
                if (px_count !== 160)
                    report_error($sformatf("%s line %0d pixel count", name, line),
                                 160, px_count);
                px_count = 0;
            end
        end
    endtask

    task automatic lcd_off();
        int k;
        tests_run++;
        write_reg(ppu_pkg::ADDR_LCDC, 8'h00);
        write_reg(ppu_pkg::ADDR_LCDC, 8'h91);
        repeat (120) @(negedge clk);                    // Into RENDER of line 0
        write_reg(ppu_pkg::ADDR_LCDC, 8'h11);
        addr = ppu_pkg::ADDR_LY;
        for (k = 1; k <= 1000; k++)
        begin
            @(negedge clk);
            if (mmio_rdata !== 8'h00)
                report_error("lcd_off LY", 8'h00, mmio_rdata);
            if (mode !== ppu_pkg::HBLANK)
                report_error("lcd_off mode", ppu_pkg::HBLANK, mode);
            if (px_valid !== 1'b0)
                report_error("lcd_off px_valid", 1'b0, px_valid);
            if (ppu_rd !== 1'b0)
                report_error("lcd_off ppu_rd", 1'b0, ppu_rd);
        end
    endtask

    task automatic stat_coincidence();
        int k;
        int pulses;
        logic want_coin;
        logic want_irq;
        tests_run++;
        write_reg(ppu_pkg::ADDR_LCDC, 8'h00);
        write_reg(ppu_pkg::ADDR_LYC, 8'd5);
        write_reg(ppu_pkg::ADDR_STAT, 8'h40);
        write_reg(ppu_pkg::ADDR_LCDC, 8'h91);
        addr   = ppu_pkg::ADDR_STAT;
        pulses = 0;
        for (k = 1; k <= FRAME_CYCLES; k++)
        begin
            @(negedge clk);
            want_coin = (k > 5 * LINE_CYCLES) && (k <= 6 * LINE_CYCLES);    // LY is 5
            want_irq  = (k == 5 * LINE_CYCLES + 2);                         // One cycle later
            if (mmio_rdata[2] !== want_coin)
                report_error($sformatf("stat_coincidence bit 2 at %0d", k),
                             want_coin, mmio_rdata[2]);
            if (mmio_rdata[7] !== 1'b1)
                report_error("stat_coincidence bit 7", 1'b1, mmio_rdata[7]);
            if (irq_stat !== want_irq)
                report_error($sformatf("stat_coincidence irq_stat at %0d", k),
                             want_irq, irq_stat);
            if (irq_stat)
                pulses++;
        end
        if (pulses !== 1)
            report_error("stat_coincidence pulses", 1, pulses);
    endtask

    task automatic stat_hblank();
        int k;
        int dot;
        int pulses;
        tests_run++;
        write_reg(ppu_pkg::ADDR_LCDC, 8'h00);
        write_reg(ppu_pkg::ADDR_STAT, 8'h00);
        write_reg(ppu_pkg::ADDR_LCDC, 8'h91);
        write_reg(ppu_pkg::ADDR_STAT, 8'h08);           // Lands in OAM_SCAN of line 0
        pulses = 0;
        for (k = 3; k <= HBLANK_LINES * LINE_CYCLES; k++)
        begin
            @(negedge clk);
            dot = (k - 1) % LINE_CYCLES;
            if (irq_stat)
                pulses++;
            if (dot == LINE_CYCLES - 1)
            begin
                if (pulses !== 1)
                    report_error($sformatf("stat_hblank line %0d pulses",
                                           (k - 1) / LINE_CYCLES),
                                 1, pulses);
                pulses = 0;
            end
        end
        write_reg(ppu_pkg::ADDR_LCDC, 8'h00);
    endtask

    initial
    begin
        clk        = 1'b0;
        rst        = 1'b1;
        addr       = '0;
        wr         = 1'b0;
        mmio_wdata = '0;
        lfsr       = 16'd76;
        load_vram();
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        register_access();
        frame_timing();
        background_pixels("bg map 9800 tiles 8000", 8'h91, 8'd3, 8'd5, VISIBLE_LINES);
        background_pixels("bg map 9C00 tiles 9000", 8'h89, 8'd13, 8'd250, 40);
        background_pixels("bg map 9C00 tiles 8000", 8'h99, 8'd7, 8'd129, 20);
        background_pixels("bg map 9800 tiles 9000", 8'h81, 8'd201, 8'd77, 20);
        background_pixels("bg disabled", 8'h90, 8'd5, 8'd9, 4);
        lcd_off();
        stat_coincidence();
        stat_hblank();

        $display("Tests run: %0d, errors: %0d", tests_run, error_count);
        if (error_count == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

/* tb/vram_model.sv */
`timescale 1ns/1ns

module vram_model
(
    input  ppu_pkg::vaddr_t addr,
    input  logic            rd,
    output ppu_pkg::byte_t  data
);

    // 8 KiB covering 8000 to 9FFF, contents written by the testbench
    ppu_pkg::byte_t mem [0:8191];

    logic in_range;

    assign in_range = (addr[15:13] == 3'b100);

    // Same-cycle read, anything outside the window reads FF
    assign data = (rd && in_range) ? mem[addr[12:0]] : 8'hFF;

endmodule
